/* hw/pd_pkg.sv */
/*
	Decoder package with word, field and class widths, class codes,
	R0 flag positions, IN/OU opcodes and the instruction word union
*/
package pd_pkg;

	localparam int WORD_W = 16;	// Instruction word
	localparam int R0_W = 9;	// Upper R0 flags
	localparam int CLS_W = 4;	// Class code
	localparam int OP_W = 6;	// Opcode field
	localparam int FLD_W = 3;	// A, B, C register fields
	localparam int T_W = 6;	// Short argument magnitude

	// Opcode classes
	localparam logic [CLS_W-1:0] CLS_ILL = 4'd0;	// 000-017, 037
	localparam logic [CLS_W-1:0] CLS_NA = 4'd1;	// 020-036, 040-057
	localparam logic [CLS_W-1:0] CLS_KA1 = 4'd2;	// 060-066
	localparam logic [CLS_W-1:0] CLS_JS = 4'd3;	// 067
	localparam logic [CLS_W-1:0] CLS_KA2 = 4'd4;	// 070
	localparam logic [CLS_W-1:0] CLS_C = 4'd5;	// 071
	localparam logic [CLS_W-1:0] CLS_S = 4'd6;	// 072
	localparam logic [CLS_W-1:0] CLS_J = 4'd7;	// 073
	localparam logic [CLS_W-1:0] CLS_L = 4'd8;	// 074-075
	localparam logic [CLS_W-1:0] CLS_G = 4'd9;	// 076
	localparam logic [CLS_W-1:0] CLS_BN = 4'd10;	// 077

	// R0 flag bit positions, Z is the leftmost bit
	localparam int R0_Z = 8;	// Zero
	localparam int R0_M = 7;	// Minus
	localparam int R0_V = 6;	// Overflow
	localparam int R0_C = 5;	// Carry
	localparam int R0_L = 4;	// Less
	localparam int R0_E = 3;	// Equal
	localparam int R0_G = 2;	// Greater
	localparam int R0_Y = 1;	// Y shift flag
	localparam int R0_X = 0;	// X shift flag

	localparam logic [OP_W-1:0] OP_IN = 6'o44;	// IN
	localparam logic [OP_W-1:0] OP_OU = 6'o45;	// OU

	// IN/OU privileged in user mode
	localparam logic INOU_USER_ILLEGAL = 1'b1;

	// One IR word, bit 15 here is IR[0]
	typedef union packed {
		struct packed {
			logic [OP_W-1:0] op;	// IR[0:5]
			logic d;	// IR[6], D modifier
			logic [FLD_W-1:0] a;	// IR[7:9]
			logic [FLD_W-1:0] b;	// IR[10:12]
			logic [FLD_W-1:0] c;	// IR[13:15]
		} nrm;	// Register fields
		struct packed {
			logic [OP_W-1:0] op;	// IR[0:5]
			logic sign;	// IR[6], negative argument
			logic [FLD_W-1:0] a;	// IR[7:9]
			logic [T_W-1:0] t;	// IR[10:15]
		} sht;	// Short argument
	} ir_word_u;

endpackage

/* hw/ir_bus_if.sv */
/*
	Latched instruction bus from the IR stage to the decoders
*/
`timescale 1ns/10ps

interface ir_bus_if import pd_pkg::*; ();

	logic valid;	// IR holds a word
	logic ready;	// Result stage can take it
	ir_word_u word;	// Latched instruction
	logic q;	// User mode at fetch
	logic [R0_W-1:0] r0;	// Flags at fetch

	// IR stage side
	modport src (
		output valid,
		output word,
		output q,
		output r0,
		input ready
	);

	// Decoder side, read only
	modport snk (
		input valid,
		input word,
		input q,
		input r0
	);

endinterface

/* hw/ir_reg.sv */
/*
	Instruction register stage, one entry with valid/ready handshake
	and invalidate
*/
`timescale 1ns/10ps

module ir_reg import pd_pkg::*; (
	input logic __clk,
	input logic rst,
	input logic si,	// Invalidate IR
	input logic in_valid,
	output logic in_ready,
	input ir_word_u in_word,
	input logic in_q,
	input logic [R0_W-1:0] in_r0,
	ir_bus_if.src irb
);

	logic run;	// Set one edge after reset
	logic vld;	// IR valid
	ir_word_u word_r;	// IR payload
	logic q_r;
	logic [R0_W-1:0] r0_r;

	// Take a word when empty or being drained, never while invalidating
	assign in_ready = run & ~si & (~vld | irb.ready);

	always_ff @(posedge __clk) begin
		if (rst) begin
			run <= 1'b0;
			vld <= 1'b0;
		end else begin
			run <= 1'b1;
			if (si)
				vld <= 1'b0;	// Drop word in flight
			else if (in_ready)
				vld <= in_valid;	// Refill or go empty
		end
	end

	// Payload only moves on a transfer
	always_ff @(posedge __clk) begin
		if (in_valid & in_ready) begin
			word_r <= in_word;
			q_r <= in_q;
			r0_r <= in_r0;
		end
	end

	assign irb.valid = vld;
	assign irb.word = word_r;
	assign irb.q = q_r;
	assign irb.r0 = r0_r;

endmodule

/* hw/group_dec.sv */
/*
	Opcode group decoder with subgroup select, register field
	and short argument extraction, B==0 and C!=0 flags
*/
`timescale 1ns/10ps

module group_dec import pd_pkg::*; (
	ir_bus_if.snk irb,
	output logic [CLS_W-1:0] cls,	// Opcode class
	output logic [FLD_W-1:0] sub,	// Subgroup selector
	output logic [WORD_W-1:0] arg,	// Fields or short argument
	output logic b0,	// B field is zero
	output logic c0	// C field nonzero, argument in next word
);

	logic [OP_W-1:0] op;
	logic [FLD_W-1:0] fa;
	logic [FLD_W-1:0] fb;
	logic [FLD_W-1:0] fc;
	logic sgn;
	logic [T_W-1:0] t;
	logic short_arg;	// KA1 or JS
	logic [WORD_W-1:0] arg_short;
	logic [WORD_W-1:0] arg_fields;

	// Normal view
	assign op = irb.word.nrm.op;
	assign fa = irb.word.nrm.a;
	assign fb = irb.word.nrm.b;
	assign fc = irb.word.nrm.c;

	// Short view of the same word
	assign sgn = irb.word.sht.sign;
	assign t = irb.word.sht.t;

	assign b0 = (fb == '0);
	assign c0 = (fc != '0);

	// Opcode group table
	always_comb begin
		case (op) inside
			[6'o20:6'o36]: cls = CLS_NA;	// First normal-argument range
			[6'o40:6'o57]: cls = CLS_NA;	// Second range, IN/OU among them
			[6'o60:6'o66]: cls = CLS_KA1;	// AWT, TRB, IRB and the rest
			6'o67: cls = CLS_JS;
			6'o70: cls = CLS_KA2;	// Byte ops, BRC/BLC, EXL, NRF
			6'o71: cls = CLS_C;	// Register ops, shifts
			6'o72: cls = CLS_S;	// HLT, MCL, SIx, GIx, LIP
			6'o73: cls = CLS_J;	// Conditional jumps
			6'o74,
			6'o75: cls = CLS_L;
			6'o76: cls = CLS_G;
			6'o77: cls = CLS_BN;	// MB, IM, KI, FI, SP, MD, RZ, IB
			default: cls = CLS_ILL;	// 000-017 and the 037 gap
		endcase
	end

	// C group with B==0 is selected by C, everything else by A
	always_comb begin
		if ((cls == CLS_C) && b0)
			sub = fc;
		else
			sub = fa;
	end

	assign short_arg = (cls == CLS_KA1) || (cls == CLS_JS);

	// T extended with the sign bit
	assign arg_short = {{(WORD_W - T_W){sgn}}, t};

	// A, B, C packed at the bottom
	assign arg_fields = {{(WORD_W - 3 * FLD_W){1'b0}}, fa, fb, fc};

	assign arg = short_arg ? arg_short : arg_fields;

endmodule

/* hw/nef_check.sv */
/*
	Illegal and ineffective instruction checks from class, fields,
	user mode and R0 flags
*/
`timescale 1ns/10ps

module nef_check import pd_pkg::*; (
	ir_bus_if.snk irb,
	input logic [CLS_W-1:0] cls,
	output logic xi,	// Illegal
	output logic nef	// Ineffective
);

	logic [OP_W-1:0] op;
	logic [FLD_W-1:0] fa;
	logic [FLD_W-1:0] fb;
	logic [R0_W-1:0] r0;
	logic is_j;
	logic is_js;
	logic ill_user;	// Privileged op in user mode
	logic ill_code;	// Undefined encoding
	logic inou;
	logic jfail;	// Jump condition not met

	assign op = irb.word.nrm.op;
	assign fa = irb.word.nrm.a;
	assign fb = irb.word.nrm.b;
	assign r0 = irb.r0;

	assign is_j = (cls == CLS_J);
	assign is_js = (cls == CLS_JS);
	assign inou = (op == OP_IN) || (op == OP_OU);

	assign ill_user = irb.q & ((cls == CLS_S)
		| ((cls == CLS_BN) & (fa < 3'd5))	// MB to SP
		| (INOU_USER_ILLEGAL & inou));

	assign ill_code = (cls == CLS_ILL)
		| ((cls == CLS_S) & (fa >= 3'd5))	// No S op above LIP
		| ((cls == CLS_C) & (fb[2] | (fb[1] & fb[0])));	// IR[10] or IR[11:12]

	assign xi = ill_user | ill_code;

	// Needed flag per A field
	always_comb begin
		jfail = 1'b0;
		if (is_j) begin
			case (fa)
				3'd1: jfail = ~r0[R0_L];	// JL
				3'd2: jfail = ~r0[R0_E];	// JE
				3'd3: jfail = ~r0[R0_G];	// JG
				3'd4: jfail = ~r0[R0_Z];	// JZ
				3'd5: jfail = ~r0[R0_M];	// JM
				3'd6: jfail = r0[R0_E];	// JN
				default: jfail = 1'b0;	// UJ, LJ
			endcase
		end else if (is_js) begin
			case (fa)
				3'd1: jfail = ~r0[R0_L];
				3'd2: jfail = ~r0[R0_E];
				3'd3: jfail = ~r0[R0_G];
				3'd4: jfail = ~r0[R0_V];	// JVS
				3'd5: jfail = ~r0[R0_X];	// JXS
				3'd6: jfail = ~r0[R0_Y];	// JYS
				3'd7: jfail = ~r0[R0_C];	// JCS
				default: jfail = 1'b0;	// UJS
			endcase
		end
	end

	assign nef = xi | jfail;

endmodule

/* hw/pd_core.sv */
/*
	Instruction decoder top with IR stage, group decoder,
	legality checks and the output result register
*/
`timescale 1ns/10ps

module pd_core import pd_pkg::*; (
	input logic __clk,
	input logic rst,
	input logic si,	// Invalidate both stages
	input logic in_valid,
	output logic in_ready,
	input logic [WORD_W-1:0] in_word,
	input logic in_q,	// User mode
	input logic [R0_W-1:0] in_r0,
	output logic res_valid,
	input logic res_ready,
	output logic [CLS_W-1:0] res_class,
	output logic [FLD_W-1:0] res_sub,
	output logic [WORD_W-1:0] res_arg,
	output logic res_b0,
	output logic res_c0,
	output logic res_xi,
	output logic res_nef
);

	ir_bus_if irb ();

	logic [CLS_W-1:0] cls;
	logic [FLD_W-1:0] sub;
	logic [WORD_W-1:0] arg;
	logic b0;
	logic c0;
	logic xi;
	logic nef;

	ir_reg u_ir_reg (
		.__clk(__clk),
		.rst(rst),
		.si(si),
		.in_valid(in_valid),
		.in_ready(in_ready),
		.in_word(in_word),
		.in_q(in_q),
		.in_r0(in_r0),
		.irb(irb.src)
	);

	group_dec u_group_dec (
		.irb(irb.snk),
		.cls(cls),
		.sub(sub),
		.arg(arg),
		.b0(b0),
		.c0(c0)
	);

	nef_check u_nef_check (
		.irb(irb.snk),
		.cls(cls),
		.xi(xi),
		.nef(nef)
	);

	// Result slot free or leaving this edge
	assign irb.ready = ~res_valid | res_ready;

	always_ff @(posedge __clk) begin
		if (rst)
			res_valid <= 1'b0;
		else if (si)
			res_valid <= 1'b0;	// Drop undelivered result
		else if (irb.ready)
			res_valid <= irb.valid;
	end

	always_ff @(posedge __clk) begin
		if (irb.valid & irb.ready) begin
			res_class <= cls;
			res_sub <= sub;
			res_arg <= arg;
			res_b0 <= b0;
			res_c0 <= c0;
			res_xi <= xi;
			res_nef <= nef;
		end
	end

endmodule

/* verif/pd_model.svh */
/*
	Reference model for the decoder: opcode class table, subgroup,
	argument, B/C flags, illegal and ineffective judgement
*/
`ifndef PD_MODEL_SVH
`define PD_MODEL_SVH

// IR bits are numbered from the left, IR[0] is the word MSB
function automatic logic ir_bit(input logic [15:0] w, input int i);
	return w[15 - i];
endfunction

// Flag by letter, R0 order is Z M V C L E G Y X from the left
function automatic logic r0_flag(input logic [8:0] r0, input byte name);
	string order;
	order = "ZMVCLEGYX";
	for (int i = 0; i < 9; i++) begin
		if (order[i] == name)
			return r0[8 - i];
	end
	return 1'b0;
endfunction

function automatic logic [3:0] model_class(input logic [5:0] op);
	if (op <= 6'o17 || op == 6'o37)
		return CLS_ILL;	// Low range and the gap
	if (op <= 6'o57)
		return CLS_NA;
	if (op <= 6'o66)
		return CLS_KA1;
	case (op)
		6'o67: return CLS_JS;
		6'o70: return CLS_KA2;
		6'o71: return CLS_C;
		6'o72: return CLS_S;
		6'o73: return CLS_J;
		6'o74,
		6'o75: return CLS_L;
		6'o76: return CLS_G;
		default: return CLS_BN;
	endcase
endfunction

// Expected {class, sub, arg, b0, c0, xi, nef}
function automatic logic [26:0] model_result(input logic [15:0] w, input logic q,
		input logic [8:0] r0);
	logic [3:0] cls;
	logic [2:0] a;
	logic [2:0] b;
	logic [2:0] c;
	logic [2:0] sub;
	logic [15:0] arg;
	logic xi;
	logic jump_ok;
	a = w[8:6];
	b = w[5:3];
	c = w[2:0];
	cls = model_class(w[15:10]);
	sub = (cls == CLS_C && b == 0) ? c : a;
	if (cls == CLS_KA1 || cls == CLS_JS)
		arg = w[9] ? (16'hffc0 | w[5:0]) : {10'd0, w[5:0]};	// Signed short argument
	else
		arg = {7'd0, w[8:0]};	// A, B, C as they stand
	xi = (cls == CLS_ILL);
	xi |= q && cls == CLS_S;
	xi |= q && cls == CLS_BN && a < 5;
	xi |= cls == CLS_S && a >= 5;
	xi |= cls == CLS_C && (ir_bit(w, 10) || (ir_bit(w, 11) && ir_bit(w, 12)));
	xi |= INOU_USER_ILLEGAL && q && (w[15:10] == OP_IN || w[15:10] == OP_OU);
	jump_ok = 1'b1;
	if (cls == CLS_J) begin
		case (a)
			3'd1: jump_ok = r0_flag(r0, "L");
			3'd2: jump_ok = r0_flag(r0, "E");
			3'd3: jump_ok = r0_flag(r0, "G");
			3'd4: jump_ok = r0_flag(r0, "Z");
			3'd5: jump_ok = r0_flag(r0, "M");
			3'd6: jump_ok = !r0_flag(r0, "E");	// Not equal
			default: jump_ok = 1'b1;
		endcase
	end else if (cls == CLS_JS) begin
		case (a)
			3'd1: jump_ok = r0_flag(r0, "L");
			3'd2: jump_ok = r0_flag(r0, "E");
			3'd3: jump_ok = r0_flag(r0, "G");
			3'd4: jump_ok = r0_flag(r0, "V");
			3'd5: jump_ok = r0_flag(r0, "X");
			3'd6: jump_ok = r0_flag(r0, "Y");
			3'd7: jump_ok = r0_flag(r0, "C");
			default: jump_ok = 1'b1;
		endcase
	end
	return {cls, sub, arg, b == 0, c != 0, xi, xi || !jump_ok};
endfunction

`endif

/* verif/tb_pd.sv */
/*
	Testbench for the decoder core with clock, reset, LFSR stimulus,
	expected-result queue from the model, checks and timeout
*/
`timescale 1ns/10ps

module tb_pd import pd_pkg::*; ();

	`include "pd_model.svh"

	localparam int N_WORDS = 2000;
	localparam int TIMEOUT = 4 * N_WORDS + 100;

	logic __clk;
	logic rst;
	logic si;
	logic in_valid;
	logic in_ready;
	logic [WORD_W-1:0] in_word;
	logic in_q;
	logic [R0_W-1:0] in_r0;
	logic res_valid;
	logic res_ready;
	logic [CLS_W-1:0] res_class;
	logic [2:0] res_sub;
	logic [WORD_W-1:0] res_arg;
	logic res_b0;
	logic res_c0;
	logic res_xi;
	logic res_nef;

	logic [31:0] lfsr = 32'hb386_3644;
	logic [42:0] pend[$];	// Word and expected result in arrival order
	int cyc = 0;	// Rising edges so far
	int errors = 0;
	int accepted = 0;
	int delivered = 0;
	int si_count = 0;
	int first_in = -1;	// Edge count before first input transfer
	logic warm = 1'b1;	// No stalls or si until first result
	logic hold = 1'b0;	// Word offered and not taken

	pd_core uut (.*);

	initial begin
		__clk = 1'b0;
		forever #50 __clk = ~__clk;
	end

	// Fibonacci LFSR with taps 32 22 2 1 stepped once per bit
	function automatic logic [31:0] lfsr_bits(input int n);
		logic [31:0] v;
		logic fb;
		v = '0;
		for (int i = 0; i < n; i++) begin
			fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
			lfsr = {lfsr[30:0], fb};
			v = {v[30:0], fb};
		end
		return v;
	endfunction

	task automatic stop_run();
		$display("FAIL: see errors above");
		$fatal(1, "simulation stopped at cycle %0d", cyc);
	endtask

	task automatic check(input string name, input logic [31:0] exp,
			input logic [31:0] act);
		if (exp !== act) begin
			errors++;
			$display("FAIL %s expected %0h actual %0h", name, exp, act);
			stop_run();
		end
	endtask

	task automatic compare_result(input logic [42:0] e);
		string w;
		w = $sformatf(" word %h", e[42:27]);
		check({"class", w}, e[26:23], res_class);
		check({"sub", w}, e[22:20], res_sub);
		check({"arg", w}, e[19:4], res_arg);
		check({"b0", w}, e[3], res_b0);
		check({"c0", w}, e[2], res_c0);
		check({"xi", w}, e[1], res_xi);
		check({"nef", w}, e[0], res_nef);
	endtask

	// Called 1 ns after the rising edge
	task automatic drive_inputs();
		if (!hold) begin
			in_valid = (accepted < N_WORDS) && (lfsr_bits(2) != 0);
			in_word = 16'(lfsr_bits(16));
			in_q = 1'(lfsr_bits(1));
			in_r0 = 9'(lfsr_bits(9));
		end
		if (warm) begin
			res_ready = 1'b1;
			si = 1'b0;
		end else begin
			res_ready = (lfsr_bits(2) != 0);	// Stall one cycle in four
			si = (lfsr_bits(6) == 0);
		end
	endtask

	// Runs at the falling edge to see what the next rising edge transfers
	task automatic sample_outputs();
		logic [42:0] e;
		if (res_valid && res_ready) begin
			if (pend.size() == 0) begin
				$display("A result was delivered while no word was pending");
				stop_run();
			end
			e = pend.pop_front();
			compare_result(e);
			delivered++;
		end
		if (warm && res_valid) begin
			check("first result latency", 2, cyc - first_in);
			warm = 1'b0;
		end
		if (in_valid && in_ready) begin
			pend.push_back({in_word, model_result(in_word, in_q, in_r0)});
			accepted++;
			if (first_in < 0)
				first_in = cyc;
		end
		if (si) begin
			pend.delete();	// In-flight words are dropped
			si_count++;
		end
		hold = in_valid && !in_ready;
	endtask

	always @(posedge __clk) begin
		cyc = cyc + 1;
		if (cyc >= TIMEOUT) begin
			$display("Timeout: %0d of %0d words accepted after %0d cycles",
				accepted, N_WORDS, cyc);
			stop_run();
		end
	end

	initial begin
		rst = 1'b1;
		si = 1'b0;
		in_valid = 1'b0;
		in_word = '0;
		in_q = 1'b0;
		in_r0 = '0;
		res_ready = 1'b0;
		repeat (8) begin
			@(posedge __clk);
			#1;
			check("reset in_ready", 0, in_ready);
			check("reset res_valid", 0, res_valid);
		end
		rst = 1'b0;
		while (accepted < N_WORDS || pend.size() != 0) begin
			drive_inputs();
			@(negedge __clk);
			sample_outputs();
			@(posedge __clk);
			#1;
		end
		// Last transfer or si takes effect on this edge
		@(posedge __clk);
		#1;
		in_valid = 1'b0;
		res_ready = 1'b1;
		si = 1'b0;
		@(negedge __clk);
		check("res_valid after drain", 0, res_valid);
		check("si pulses seen", 1, si_count != 0);
		$display("%0d words accepted, %0d results compared, %0d si pulses",
			accepted, delivered, si_count);
		if (errors == 0) begin
			$display("PASS: all tests");
			$finish;
		end else begin
			$display("FAIL: see errors above");
			$fatal(1, "%0d mismatches", errors);
		end
	end

endmodule

/* files.f */
+incdir+verif
hw/pd_pkg.sv
hw/ir_bus_if.sv
hw/ir_reg.sv
hw/group_dec.sv
hw/nef_check.sv
hw/pd_core.sv
verif/tb_pd.sv
